/* src/mchan_sync_pkg.sv */
// Shared widths and types for the DMA completion tracker.
// A transfer length is a byte count of up to 64 KiB minus one.
// CNT_WIDTH holds two maximum requests at the smallest burst of 16 bytes,
// so a counter never wraps as long as a sid has at most two requests open.

package mchan_sync_pkg;

   // ******************************
   // Widths
   // ******************************

   localparam int unsigned LEN_WIDTH = 16;
   localparam int unsigned SID_WIDTH = 3;
   localparam int unsigned CNT_WIDTH = 14;

   // ******************************
   // Interface structs
   // ******************************

   // One transfer request for one direction, qualified by its own gnt level
   typedef struct packed {
      logic                 req;
      logic [SID_WIDTH-1:0] sid;
      logic [LEN_WIDTH-1:0] len;
   } xfer_req_t;

   // One release strobe, worth exactly one burst
   typedef struct packed {
      logic                 req;
      logic [SID_WIDTH-1:0] sid;
   } rel_t;

   // An accepted request, already converted to a burst count
   typedef struct packed {
      logic                 valid;
      logic [SID_WIDTH-1:0] sid;
      logic [CNT_WIDTH-1:0] nb;
   } cmd_t;

   // Per-sid completion state
   typedef enum logic {
      IDLE = 1'b0,
      BUSY = 1'b1
   } sid_state_e;

endpackage

/* src/cmd_decoder.sv */
// Turns granted tx and rx requests into burst-count commands.
// BURST_BYTES must be a power of two and at least 16.
// Purely combinational, so a command is valid only in the granting cycle.
// A granted zero-length request gives zero bursts and is flagged.

`timescale 1ns/100ps

module cmd_decoder
#(
   parameter int unsigned BURST_BYTES = 64
)
(
   input  mchan_sync_pkg::xfer_req_t tx_req_i,
   input  mchan_sync_pkg::xfer_req_t rx_req_i,
   input  logic                      tx_gnt_i,
   input  logic                      rx_gnt_i,
   output mchan_sync_pkg::cmd_t      tx_cmd_o,
   output mchan_sync_pkg::cmd_t      rx_cmd_o
);

   import mchan_sync_pkg::*;

   localparam int unsigned OFFS_W = $clog2(BURST_BYTES);
   localparam logic [LEN_WIDTH-1:0] OFFS_MASK = LEN_WIDTH'(BURST_BYTES - 1);

   // Length divided by the burst size, rounded up
   function automatic logic [CNT_WIDTH-1:0] burst_count(input logic [LEN_WIDTH-1:0] len);
      logic [LEN_WIDTH-1:0] whole;
      logic                 part;
      whole = len >> OFFS_W;
      part  = |(len & OFFS_MASK);
      return CNT_WIDTH'(whole + LEN_WIDTH'(part));
   endfunction

   // ******************************
   // Command generation
   // ******************************

   assign tx_cmd_o.valid = tx_req_i.req & tx_gnt_i;
   assign tx_cmd_o.sid   = tx_req_i.sid;
   assign tx_cmd_o.nb    = burst_count(tx_req_i.len);

   assign rx_cmd_o.valid = rx_req_i.req & rx_gnt_i;
   assign rx_cmd_o.sid   = rx_req_i.sid;
   assign rx_cmd_o.nb    = burst_count(rx_req_i.len);

   // A zero-length transfer would never see a release and never terminate
   always_comb
   begin
      assert final (!tx_cmd_o.valid || (tx_req_i.len != '0))
         else $error("tx request granted with zero length on sid %0d", tx_req_i.sid);
      assert final (!rx_cmd_o.valid || (rx_req_i.len != '0))
         else $error("rx request granted with zero length on sid %0d", rx_req_i.sid);
   end

endmodule

/* src/outstanding_counter.sv */
// Outstanding burst counter for one side (tcdm or ext) of one sid.
// Two increments and up to two decrements may land in the same cycle.
// A release with no burst left to match is an error of the burst engines
// and is only flagged, the counter wraps in that case.

`timescale 1ns/100ps

module outstanding_counter
(
   input  logic                                 clk_i,
   input  logic                                 rst_ni,
   input  logic [mchan_sync_pkg::CNT_WIDTH-1:0] add_a_i,
   input  logic [mchan_sync_pkg::CNT_WIDTH-1:0] add_b_i,
   input  logic [1:0]                           sub_nb_i,
   output logic                                 nonzero_o
);

   import mchan_sync_pkg::*;

   // Two extra bits so the sum of three counts cannot wrap before the subtraction
   localparam int unsigned SUM_W = CNT_WIDTH + 2;

   logic [CNT_WIDTH-1:0] cnt_q;
   logic [CNT_WIDTH-1:0] cnt_d;
   logic [SUM_W-1:0]     inc_sum;
   logic [SUM_W-1:0]     sub_ext;

   // ******************************
   // Next count
   // ******************************

   assign inc_sum = SUM_W'(cnt_q) + SUM_W'(add_a_i) + SUM_W'(add_b_i);
   assign sub_ext = SUM_W'(sub_nb_i);

   // All sixteen request and release combinations fold into one sum
   assign cnt_d = CNT_WIDTH'(inc_sum - sub_ext);

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         cnt_q <= '0;
      end
      else
      begin
         cnt_q <= cnt_d;
      end
   end

   assign nonzero_o = |cnt_q;

   // ******************************
   // Checks
   // ******************************

   // Releases may only retire bursts that were requested before or in this cycle
   underflow_a : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      inc_sum >= sub_ext
   )
   else $error("release count %0d exceeds outstanding %0d plus new bursts",
               sub_nb_i, cnt_q);

   // The result must fit the counter, i.e. no more than two full requests open
   overflow_a : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (inc_sum - sub_ext) < SUM_W'(2 ** CNT_WIDTH)
   )
   else $error("outstanding burst count overflows %0d bits", CNT_WIDTH);

endmodule

/* src/sid_status_fsm.sv */
// Busy and termination tracking for one sid.
// pending_i is high while either outstanding counter of the sid is nonzero.
// term_o is a one-cycle pulse in the cycle after the last release, and
// trans_status_o stays high through that cycle.
// A new request in the termination cycle keeps the sid busy, but the pulse
// for the finished work is still given.

`timescale 1ns/100ps

module sid_status_fsm
(
   input  logic clk_i,
   input  logic rst_ni,
   input  logic pending_i,
   output logic trans_status_o,
   output logic term_o
);

   import mchan_sync_pkg::*;

   sid_state_e state_q;
   sid_state_e state_d;

   // ******************************
   // State machine
   // ******************************

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (pending_i)
               state_d = BUSY;
         end
         BUSY:
         begin
            if (!pending_i)
               state_d = IDLE;
         end
         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   // Status rises with the counters and falls one cycle after they drain
   assign trans_status_o = pending_i | (state_q == BUSY);
   assign term_o         = (state_q == BUSY) & ~pending_i;

endmodule

/* src/synch_unit.sv */
// Completion tracking for a single sid.
// Only commands and releases tagged with SID are counted here.
// Both directions share the two counters, one for the tcdm side and one
// for the external side, so a sid is busy until both sides have drained.

`timescale 1ns/100ps

module synch_unit
#(
   parameter int unsigned SID = 0
)
(
   input  logic                 clk_i,
   input  logic                 rst_ni,
   input  mchan_sync_pkg::cmd_t tx_cmd_i,
   input  mchan_sync_pkg::cmd_t rx_cmd_i,
   input  mchan_sync_pkg::rel_t ext_tx_rel_i,
   input  mchan_sync_pkg::rel_t ext_rx_rel_i,
   input  mchan_sync_pkg::rel_t tcdm_tx_rel_i,
   input  mchan_sync_pkg::rel_t tcdm_rx_rel_i,
   output logic                 trans_status_o,
   output logic                 term_o
);

   import mchan_sync_pkg::*;

   localparam logic [SID_WIDTH-1:0] OWN_SID = SID_WIDTH'(SID);

   logic [CNT_WIDTH-1:0] tx_add;
   logic [CNT_WIDTH-1:0] rx_add;
   logic [1:0]           tcdm_sub_nb;
   logic [1:0]           ext_sub_nb;
   logic                 tcdm_nonzero;
   logic                 ext_nonzero;
   logic                 pending;

   function automatic logic rel_hit(input rel_t rel);
      return rel.req && (rel.sid == OWN_SID);
   endfunction

   // ******************************
   // Sid matching
   // ******************************

   assign tx_add = (tx_cmd_i.valid && (tx_cmd_i.sid == OWN_SID)) ? tx_cmd_i.nb : '0;
   assign rx_add = (rx_cmd_i.valid && (rx_cmd_i.sid == OWN_SID)) ? rx_cmd_i.nb : '0;

   // Both directions may release on the same side in one cycle
   assign tcdm_sub_nb = {1'b0, rel_hit(tcdm_tx_rel_i)} + {1'b0, rel_hit(tcdm_rx_rel_i)};
   assign ext_sub_nb  = {1'b0, rel_hit(ext_tx_rel_i)} + {1'b0, rel_hit(ext_rx_rel_i)};

   // ******************************
   // Counters and status
   // ******************************

   outstanding_counter tcdm_cnt_inst (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .add_a_i   (tx_add),
      .add_b_i   (rx_add),
      .sub_nb_i  (tcdm_sub_nb),
      .nonzero_o (tcdm_nonzero)
   );

   outstanding_counter ext_cnt_inst (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .add_a_i   (tx_add),
      .add_b_i   (rx_add),
      .sub_nb_i  (ext_sub_nb),
      .nonzero_o (ext_nonzero)
   );

   assign pending = tcdm_nonzero | ext_nonzero;

   sid_status_fsm sid_status_fsm_inst (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .pending_i      (pending),
      .trans_status_o (trans_status_o),
      .term_o         (term_o)
   );

endmodule

/* src/mchan_sync_top.sv */
// Transfer completion tracker for a multi-channel DMA.
// NB_SIDS ranges from 1 to 8, sids at or above NB_SIDS are ignored.
// BURST_BYTES is a power of two, at least 16.
// Requests count only with their gnt high, releases are single-cycle strobes.

`timescale 1ns/100ps

module mchan_sync_top
#(
   parameter int unsigned NB_SIDS     = 4,
   parameter int unsigned BURST_BYTES = 64
)
(
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  mchan_sync_pkg::xfer_req_t tx_req_i,
   input  logic                      tx_gnt_i,
   input  mchan_sync_pkg::xfer_req_t rx_req_i,
   input  logic                      rx_gnt_i,
   input  mchan_sync_pkg::rel_t      ext_tx_rel_i,
   input  mchan_sync_pkg::rel_t      ext_rx_rel_i,
   input  mchan_sync_pkg::rel_t      tcdm_tx_rel_i,
   input  mchan_sync_pkg::rel_t      tcdm_rx_rel_i,
   output logic [NB_SIDS-1:0]        trans_status_o,
   output logic [NB_SIDS-1:0]        term_o
);

   import mchan_sync_pkg::*;

   cmd_t tx_cmd;
   cmd_t rx_cmd;

   cmd_decoder #(
      .BURST_BYTES (BURST_BYTES)
   ) cmd_decoder_inst (
      .tx_req_i (tx_req_i),
      .rx_req_i (rx_req_i),
      .tx_gnt_i (tx_gnt_i),
      .rx_gnt_i (rx_gnt_i),
      .tx_cmd_o (tx_cmd),
      .rx_cmd_o (rx_cmd)
   );

   // One tracker per sid, each picks its own traffic out of the shared buses
   for (genvar i = 0; i < NB_SIDS; i++)
   begin : gen_sid
      synch_unit #(
         .SID (i)
      ) synch_unit_inst (
         .clk_i          (clk_i),
         .rst_ni         (rst_ni),
         .tx_cmd_i       (tx_cmd),
         .rx_cmd_i       (rx_cmd),
         .ext_tx_rel_i   (ext_tx_rel_i),
         .ext_rx_rel_i   (ext_rx_rel_i),
         .tcdm_tx_rel_i  (tcdm_tx_rel_i),
         .tcdm_rx_rel_i  (tcdm_rx_rel_i),
         .trans_status_o (trans_status_o[i]),
         .term_o         (term_o[i])
      );
   end

endmodule

/* bench/sync_checker.sv */
// Reference model and scoreboard for the DMA completion tracker.
// Inputs and outputs are sampled on the falling clock edge, where both are stable.
// Sids at or above NB_SIDS are ignored, as in the DUT.

`timescale 1ns/100ps

module sync_checker
#(
   parameter int NB_SIDS     = 4,
   parameter int BURST_BYTES = 64
)
(
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  mchan_sync_pkg::xfer_req_t tx_req_i,
   input  logic                      tx_gnt_i,
   input  mchan_sync_pkg::xfer_req_t rx_req_i,
   input  logic                      rx_gnt_i,
   input  mchan_sync_pkg::rel_t      ext_tx_rel_i,
   input  mchan_sync_pkg::rel_t      ext_rx_rel_i,
   input  mchan_sync_pkg::rel_t      tcdm_tx_rel_i,
   input  mchan_sync_pkg::rel_t      tcdm_rx_rel_i,
   input  logic [NB_SIDS-1:0]        trans_status_i,
   input  logic [NB_SIDS-1:0]        term_i,
   input  logic                      row_end_i,
   input  logic [NB_SIDS-1:0]        row_mask_i,
   output int                        value_errs_o,
   output int                        pulse_errs_o
);

   import mchan_sync_pkg::*;

   int                 tcdm_cnt [NB_SIDS];
   int                 ext_cnt  [NB_SIDS];
   logic               busy     [NB_SIDS];
   int                 pulses   [NB_SIDS];
   logic [NB_SIDS-1:0] exp_status;
   logic [NB_SIDS-1:0] exp_term;
   int                 value_errs = 0;
   int                 pulse_errs = 0;

   assign value_errs_o = value_errs;
   assign pulse_errs_o = pulse_errs;

   // A partial burst at the end still needs a release of its own
   function automatic int ceil_bursts(input logic [LEN_WIDTH-1:0] len);
      return (int'(len) + BURST_BYTES - 1) / BURST_BYTES;
   endfunction

   function automatic int hits(input rel_t a, input rel_t b, input int s);
      return int'(a.req && (int'(a.sid) == s)) + int'(b.req && (int'(b.sid) == s));
   endfunction

   always @(negedge clk_i)
   begin
      if (!rst_ni)
      begin
         for (int s = 0; s < NB_SIDS; s++)
         begin
            tcdm_cnt[s] = 0;
            ext_cnt[s]  = 0;
            busy[s]     = 1'b0;
            pulses[s]   = 0;
         end
      end
      else
      begin
         // Busy while bursts are open, and for the one cycle after they drain
         for (int s = 0; s < NB_SIDS; s++)
         begin
            exp_status[s] = (tcdm_cnt[s] != 0) || (ext_cnt[s] != 0) || busy[s];
            exp_term[s]   = busy[s] && (tcdm_cnt[s] == 0) && (ext_cnt[s] == 0);
            if (term_i[s])
               pulses[s]++;
         end
         if (trans_status_i !== exp_status)
         begin
            $display("ERROR: trans_status_o expected 'h%h, got 'h%h", exp_status, trans_status_i);
            value_errs++;
         end
         if (term_i !== exp_term)
         begin
            $display("ERROR: term_o expected 'h%h, got 'h%h", exp_term, term_i);
            value_errs++;
         end
         for (int s = 0; s < NB_SIDS; s++)
         begin
            if (row_end_i && (pulses[s] != int'(row_mask_i[s])))
            begin
               $display("ERROR: term_o pulses on sid %0d expected 'h%h, got 'h%h",
                        s, row_mask_i[s], pulses[s]);
               pulse_errs++;
            end
            if (row_end_i)
               pulses[s] = 0;
            busy[s] = (tcdm_cnt[s] != 0) || (ext_cnt[s] != 0);
            if (tx_req_i.req && tx_gnt_i && (int'(tx_req_i.sid) == s))
            begin
               tcdm_cnt[s] += ceil_bursts(tx_req_i.len);
               ext_cnt[s]  += ceil_bursts(tx_req_i.len);
            end
            if (rx_req_i.req && rx_gnt_i && (int'(rx_req_i.sid) == s))
            begin
               tcdm_cnt[s] += ceil_bursts(rx_req_i.len);
               ext_cnt[s]  += ceil_bursts(rx_req_i.len);
            end
            tcdm_cnt[s] -= hits(tcdm_tx_rel_i, tcdm_rx_rel_i, s);
            ext_cnt[s]  -= hits(ext_tx_rel_i, ext_rx_rel_i, s);
            if ((tcdm_cnt[s] < 0) || (ext_cnt[s] < 0))
            begin
               $display("Release on sid %0d with no burst outstanding", s);
               value_errs++;
            end
         end
      end
   end

endmodule

/* bench/tb_mchan_sync.sv */
// Testbench for the DMA completion tracker, with NB_SIDS 4 and 64-byte bursts.
// Each table row issues requests, then releases in shuffled order with random gaps.
// STRAY_SID must lie at or above NB_SIDS so that the DUT ignores it.

`timescale 1ns/100ps

module tb_mchan_sync;

   import mchan_sync_pkg::*;

   localparam int NB_SIDS     = 4;
   localparam int BURST_BYTES = 64;
   localparam int NB_ROWS     = 7;
   localparam logic [SID_WIDTH-1:0] STRAY_SID = SID_WIDTH'(7);

   typedef struct packed {
      logic [SID_WIDTH-1:0] sid;
      logic [LEN_WIDTH-1:0] tx_len;
      logic [LEN_WIDTH-1:0] rx_len;
      logic                 gnt_gap;
      logic [SID_WIDTH-1:0] sid2;
   } row_t;

   logic               clk_i;
   logic               rst_ni;
   xfer_req_t          tx_req_i;
   xfer_req_t          rx_req_i;
   logic               tx_gnt_i;
   logic               rx_gnt_i;
   rel_t               ext_tx_rel_i;
   rel_t               ext_rx_rel_i;
   rel_t               tcdm_tx_rel_i;
   rel_t               tcdm_rx_rel_i;
   logic [NB_SIDS-1:0] trans_status_o;
   logic [NB_SIDS-1:0] term_o;
   logic               row_end;
   logic [NB_SIDS-1:0] row_mask;
   int                 value_errs;
   int                 pulse_errs;
   int                 cycle_cnt = 0;
   int                 cycle_limit = 0;
   row_t               rows [NB_ROWS];

   mchan_sync_top #(.NB_SIDS(NB_SIDS), .BURST_BYTES(BURST_BYTES)) mchan_sync_top_inst (.*);

   sync_checker #(.NB_SIDS(NB_SIDS), .BURST_BYTES(BURST_BYTES)) sync_checker_inst (
      .*,
      .trans_status_i (trans_status_o),
      .term_i         (term_o),
      .row_end_i      (row_end),
      .row_mask_i     (row_mask),
      .value_errs_o   (value_errs),
      .pulse_errs_o   (pulse_errs)
   );

   always #10 clk_i = ~clk_i;

   // ******************************
   // Helpers
   // ******************************

   function automatic int bursts_needed(input logic [LEN_WIDTH-1:0] len);
      return (int'(len) + BURST_BYTES - 1) / BURST_BYTES;
   endfunction

   // Worst case is one release per four cycles, plus slack for every row
   function automatic int run_limit();
      int total;
      total = 0;
      foreach (rows[i])
         total += 2 * (bursts_needed(rows[i].tx_len) + bursts_needed(rows[i].rx_len)) * 4 + 50;
      return total;
   endfunction

   task automatic drive_releases(input rel_t tcdm_tx, input rel_t tcdm_rx,
                                 input rel_t ext_tx, input rel_t ext_rx);
      tcdm_tx_rel_i <= tcdm_tx;
      tcdm_rx_rel_i <= tcdm_rx;
      ext_tx_rel_i  <= ext_tx;
      ext_rx_rel_i  <= ext_rx;
   endtask

   // tx goes to sid and rx to sid2, which equals sid in a row without interleaving
   task automatic send_requests(input row_t r);
      @(posedge clk_i);
      tx_req_i <= '{(r.tx_len != '0), r.sid, r.tx_len};
      rx_req_i <= '{(r.rx_len != '0), r.sid2, r.rx_len};
      tx_gnt_i <= ~r.gnt_gap;
      rx_gnt_i <= ~r.gnt_gap;
      if (r.gnt_gap)
      begin
         drive_releases('{1'b1, STRAY_SID}, '{1'b1, STRAY_SID},
                        '{1'b1, STRAY_SID}, '{1'b1, STRAY_SID});
         @(posedge clk_i);
         tx_gnt_i <= 1'b1;
         rx_gnt_i <= 1'b1;
         drive_releases('0, '0, '0, '0);
      end
      @(posedge clk_i);
      tx_req_i <= '0;
      rx_req_i <= '0;
      tx_gnt_i <= 1'b0;
      rx_gnt_i <= 1'b0;
   endtask

   // Tokens hold {side, sid}; side 0 is tcdm and side 1 is ext
   task automatic send_releases(input row_t r);
      logic [SID_WIDTH:0] tokens [$];
      logic [SID_WIDTH:0] tok;
      rel_t               slot [4];
      int                 i, j, gap, tries, base;
      for (i = 0; i < 2; i++)
      begin
         repeat (bursts_needed(r.tx_len)) tokens.push_back({i[0], r.sid});
         repeat (bursts_needed(r.rx_len)) tokens.push_back({i[0], r.sid2});
      end
      for (i = tokens.size() - 1; i > 0; i--)
      begin
         j = int'($urandom % (i + 1));
         tok = tokens[i];
         tokens[i] = tokens[j];
         tokens[j] = tok;
      end
      gap = int'($urandom % 4);
      while (tokens.size() > 0)
      begin
         @(posedge clk_i);
         foreach (slot[k])
            slot[k] = '0;
         if (gap > 0)
            gap--;
         else
         begin
            // Up to three tokens per cycle, two of them may share a side
            tries = 1 + int'($urandom % 3);
            while ((tries > 0) && (tokens.size() > 0))
            begin
               tok = tokens[0];
               base = tok[SID_WIDTH] ? 2 : 0;
               if (slot[base].req && slot[base + 1].req)
                  break;
               if (!slot[base].req)
                  slot[base] = '{1'b1, tok[SID_WIDTH-1:0]};
               else
                  slot[base + 1] = '{1'b1, tok[SID_WIDTH-1:0]};
               void'(tokens.pop_front());
               tries--;
            end
            gap = int'($urandom % 4);
         end
         drive_releases(slot[0], slot[1], slot[2], slot[3]);
      end
      @(posedge clk_i);
      drive_releases('0, '0, '0, '0);
   endtask

   task automatic finish_row(input row_t r);
      logic [NB_SIDS-1:0] mask;
      mask = (NB_SIDS'(1) << r.sid) | (NB_SIDS'(1) << r.sid2);
      do
         @(negedge clk_i);
      while ((trans_status_o & mask) != '0);
      @(posedge clk_i);
      row_end  <= 1'b1;
      row_mask <= mask;
      @(posedge clk_i);
      row_end  <= 1'b0;
   endtask

   // ******************************
   // Timeout
   // ******************************

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit))
      begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // ******************************
   // Main sequence
   // ******************************

   initial
   begin
      void'($urandom(32'h339c));
      clk_i         = 1'b0;
      rst_ni        = 1'b0;
      tx_req_i      = '0;
      rx_req_i      = '0;
      tx_gnt_i      = 1'b0;
      rx_gnt_i      = 1'b0;
      ext_tx_rel_i  = '0;
      ext_rx_rel_i  = '0;
      tcdm_tx_rel_i = '0;
      tcdm_rx_rel_i = '0;
      row_end       = 1'b0;
      row_mask      = '0;
      // Columns are sid, tx length, rx length, gnt low first, second sid
      rows[0] = '{3'd0, 16'd256, 16'd0,   1'b0, 3'd0};
      rows[1] = '{3'd1, 16'd128, 16'd0,   1'b1, 3'd1};
      rows[2] = '{3'd2, 16'd192, 16'd128, 1'b0, 3'd2};
      rows[3] = '{3'd3, 16'd100, 16'd1,   1'b0, 3'd3};
      rows[4] = '{3'd0, 16'd1,   16'd0,   1'b0, 3'd0};
      rows[5] = '{3'd1, 16'd300, 16'd65,  1'b0, 3'd3};
      rows[6] = '{3'd2, 16'd64,  16'd640, 1'b1, 3'd0};
      cycle_limit = run_limit();
      repeat (5) @(posedge clk_i);
      rst_ni <= 1'b1;
      // Idle cycles after reset, all outputs must stay low
      repeat (4) @(posedge clk_i);
      foreach (rows[i])
      begin
         send_requests(rows[i]);
         send_releases(rows[i]);
         finish_row(rows[i]);
      end
      repeat (3) @(posedge clk_i);
      $display("Error counts: value %0d, term pulse %0d", value_errs, pulse_errs);
      if ((value_errs + pulse_errs) == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* tb.f */
src/mchan_sync_pkg.sv
src/cmd_decoder.sv
src/outstanding_counter.sv
src/sid_status_fsm.sv
src/synch_unit.sv
src/mchan_sync_top.sv
bench/sync_checker.sv
bench/tb_mchan_sync.sv

/* run_sim.sh */
#!/bin/sh
# Builds the completion tracker testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module tb_mchan_sync \
   -Mdir obj_dir -o sim_mchan_sync
then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_mchan_sync)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qxF '*** TEST PASSED ***'; then
   exit 0
fi

echo "Simulation did not report a pass"
exit 1
